// ==== include/song_table.svh ====
/* melody tables for intro and chorus */

`ifndef SONG_TABLE_SVH
`define SONG_TABLE_SVH

localparam tune_pkg::note_t intro_notes [tune_pkg::intro_len] = '{
  '{554, 6},   // c5s
  '{622, 10},
  '{622, 6},
  '{698, 6},
  '{831, 1},   // a5f
  '{740, 1},
  '{698, 1},
  '{622, 1},
  '{554, 6},
  '{622, 10},
  '{0, 4},     // rest
  '{415, 2},
  '{415, 10}
};

localparam tune_pkg::note_t chorus_notes [tune_pkg::chorus_len] = '{
  '{466, 1},   // b4f
  '{466, 1},
  '{415, 1},
  '{415, 1},
  '{698, 3},
  '{698, 3},
  '{622, 6},
  '{466, 1},
  '{466, 1},
  '{415, 1},
  '{415, 1},
  '{622, 3},
  '{622, 3},
  '{554, 3},
  '{523, 1},
  '{466, 2},
  '{554, 1},
  '{554, 1},
  '{554, 1},
  '{554, 1},
  '{554, 3},
  '{622, 3},
  '{523, 3},
  '{466, 1},
  '{415, 2},
  '{415, 2},
  '{415, 2},
  '{622, 4},
  '{554, 8},
  '{466, 1},   // second half of the chorus
  '{466, 1},
  '{415, 1},
  '{415, 1},
  '{698, 3},
  '{698, 3},
  '{622, 6},
  '{466, 1},
  '{466, 1},
  '{415, 1},
  '{415, 1},
  '{831, 3},
  '{523, 3},
  '{554, 3},
  '{523, 1},
  '{466, 2},
  '{554, 1},
  '{554, 1},
  '{554, 1},
  '{554, 1},
  '{554, 3},
  '{622, 3},
  '{523, 3},
  '{466, 1},
  '{415, 2},
  '{0, 2},     // rest
  '{415, 2},
  '{622, 4},
  '{554, 8},
  '{0, 4}      // closing rest
};

// number of notes in a part
function automatic logic [5:0] song_len(tune_pkg::part_t p);
  case (p)
    tune_pkg::intro_a, tune_pkg::intro_b: return 6'(tune_pkg::intro_len);
    default: return 6'(tune_pkg::chorus_len);
  endcase
endfunction

// table lookup for one note of a part
function automatic tune_pkg::note_t song_note(tune_pkg::part_t p, logic [5:0] idx);
  case (p)
    tune_pkg::intro_a, tune_pkg::intro_b: return intro_notes[idx[3:0]];
    default: return chorus_notes[idx];
  endcase
endfunction

`endif

// ==== rtl/tune_pkg.sv ====
/* tune player shared types and constants */

`default_nettype none

package tune_pkg;

  typedef logic [9:0]  freq_t;  // hertz, zero is a rest
  typedef logic [3:0]  beats_t;
  typedef logic [10:0] ms_t;
  typedef logic [15:0] tick_t;

  // one table entry
  typedef struct packed {
    freq_t  freq;
    beats_t beats;
  } note_t;

  typedef enum logic [1:0] {
    intro_a,
    intro_b,
    chorus_a,
    chorus_b
  } part_t;

  typedef enum logic [1:0] {
    idle,
    sounding,
    gap
  } timer_state_t;

  localparam int beat_ms     = 100;  // tempo
  localparam int gap_divisor = 3;    // gap is a third of the note
  localparam int intro_len   = 13;
  localparam int chorus_len  = 59;

  // segment order is g f e d c b a, msb first
  localparam logic [6:0] digit_segments [0:9] = '{
    7'b0111111, 7'b0000110, 7'b1011011, 7'b1001111, 7'b1100110,
    7'b1101101, 7'b1111100, 7'b0000111, 7'b1111111, 7'b1100111
  };

endpackage

`default_nettype wire

// ==== rtl/song_sequencer.sv ====
/* song part and note sequencer */

`timescale 1ns/1ns
`default_nettype none

module song_sequencer (
  input  logic             clk,
  input  logic             rst,
  input  logic             take,
  output tune_pkg::freq_t  note_freq,
  output tune_pkg::beats_t note_beats,
  output logic [6:0]       segments
);

  `include "song_table.svh"

  tune_pkg::part_t part;
  logic [5:0]      index;  // note within the part
  logic            last_note;
  tune_pkg::note_t cur_note;

  assign cur_note   = song_note(part, index);
  assign note_freq  = cur_note.freq;
  assign note_beats = cur_note.beats;
  assign last_note  = (index == song_len(part) - 6'd1);

  always_ff @(posedge clk) begin
    if (rst) begin
      part  <= tune_pkg::intro_a;
      index <= '0;
    end else if (take) begin
      if (last_note) begin
        index <= '0;
        part  <= tune_pkg::part_t'(part + 2'd1);  // chorus_b wraps to intro_a
      end else begin
        index <= index + 6'd1;
      end
    end
  end

  // parts are shown as 1 to 4
  assign segments = tune_pkg::digit_segments[4'(part) + 4'd1];

  a_index_in_part: assert property (
    @(posedge clk) disable iff (rst)
    index < song_len(part)
  );

endmodule

`default_nettype wire

// ==== rtl/note_timer.sv ====
/* note and gap timer */

`timescale 1ns/1ns
`default_nettype none

module note_timer (
  input  logic             clk,
  input  logic             rst,
  input  tune_pkg::tick_t  ticks_per_milli,
  input  tune_pkg::freq_t  note_freq,
  input  tune_pkg::beats_t note_beats,
  output logic             take,
  output tune_pkg::freq_t  tone_freq,
  output logic             sounding
);

  tune_pkg::timer_state_t state;
  tune_pkg::tick_t        tick_cnt;
  tune_pkg::ms_t          ms_cnt;
  tune_pkg::ms_t          note_ms;   // length of the offered note
  tune_pkg::ms_t          sound_ms;  // latched note length
  tune_pkg::ms_t          gap_ms;
  tune_pkg::freq_t        freq_q;
  logic                   ms_strobe;

  assign ms_strobe = (tick_cnt == ticks_per_milli);
  assign note_ms   = tune_pkg::ms_t'(note_beats) * tune_pkg::ms_t'(tune_pkg::beat_ms);

  // free running millisecond prescaler
  always_ff @(posedge clk) begin
    if (rst || ms_strobe) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + 16'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= tune_pkg::idle;
      ms_cnt <= '0;
    end else begin
      case (state)
        tune_pkg::idle: begin
          ms_cnt <= '0;
          state  <= (note_beats == '0) ? tune_pkg::gap : tune_pkg::sounding;
        end
        tune_pkg::sounding: begin
          if (ms_cnt == sound_ms) begin
            ms_cnt <= '0;
            state  <= tune_pkg::gap;
          end else if (ms_strobe) begin
            ms_cnt <= ms_cnt + 11'd1;
          end
        end
        tune_pkg::gap: begin
          if (ms_cnt == gap_ms) begin
            state <= tune_pkg::idle;  // next note one cycle later
          end else if (ms_strobe) begin
            ms_cnt <= ms_cnt + 11'd1;
          end
        end
        default: state <= tune_pkg::idle;
      endcase
    end
  end

  // note payload, loaded on take
  always_ff @(posedge clk) begin
    if (take) begin
      freq_q   <= note_freq;
      sound_ms <= note_ms;
      gap_ms   <= note_ms / tune_pkg::ms_t'(tune_pkg::gap_divisor);
    end
  end

  assign take      = (state == tune_pkg::idle) && !rst;
  assign tone_freq = (state == tune_pkg::sounding) ? freq_q : '0;
  assign sounding  = (state == tune_pkg::sounding) && (freq_q != '0);  // rests stay dark

  a_take_once: assert property (
    @(posedge clk) disable iff (rst)
    take |=> (state != tune_pkg::idle) && !take
  );

  a_gap_in_range: assert property (
    @(posedge clk) disable iff (rst)
    (state == tune_pkg::gap) |-> (ms_cnt <= gap_ms)
  );

endmodule

`default_nettype wire

// ==== rtl/tone_generator.sv ====
/* square wave tone generator */

`timescale 1ns/1ns
`default_nettype none

module tone_generator (
  input  logic            clk,
  input  logic            rst,
  input  tune_pkg::tick_t ticks_per_milli,
  input  tune_pkg::freq_t freq,
  output logic            sound
);

  logic [26:0] half_period;  // half of the cycles per second
  logic [26:0] acc;
  logic [26:0] sum;

  // one millisecond is ticks_per_milli + 1 cycles
  assign half_period = ((27'(ticks_per_milli) + 27'd1) * 27'd1000) >> 1;
  assign sum         = acc + 27'(freq);

  always_ff @(posedge clk) begin
    if (rst || freq == '0) begin
      acc   <= '0;
      sound <= 1'b0;
    end else if (sum >= half_period) begin
      acc   <= sum - half_period;  // keep the remainder
      sound <= ~sound;
    end else begin
      acc <= sum;
    end
  end

  // freq must stay below the half period
  a_acc_in_range: assert property (
    @(posedge clk) disable iff (rst)
    acc < half_period
  );

endmodule

`default_nettype wire

// ==== rtl/tune_player.sv ====
/* tune player top level */

`timescale 1ns/1ns
`default_nettype none

module tune_player (
  input  logic            clk,
  input  logic            rst,
  input  tune_pkg::tick_t ticks_per_milli,
  output logic            sound,
  output logic [7:0]      led
);

  logic             take;
  tune_pkg::freq_t  note_freq;
  tune_pkg::beats_t note_beats;
  tune_pkg::freq_t  tone_freq;

  song_sequencer u_sequencer (
    .clk        (clk),
    .rst        (rst),
    .take       (take),
    .note_freq  (note_freq),
    .note_beats (note_beats),
    .segments   (led[6:0])  // part digit
  );

  note_timer u_timer (
    .clk             (clk),
    .rst             (rst),
    .ticks_per_milli (ticks_per_milli),
    .note_freq       (note_freq),
    .note_beats      (note_beats),
    .take            (take),
    .tone_freq       (tone_freq),
    .sounding        (led[7])  // dot
  );

  tone_generator u_tone (
    .clk             (clk),
    .rst             (rst),
    .ticks_per_milli (ticks_per_milli),
    .freq            (tone_freq),
    .sound           (sound)
  );

endmodule

`default_nettype wire

// ==== bench/tune_player_tb.sv ====
/* tune player testbench */

`timescale 1ns/1ns
`default_nettype none

module tune_player_tb;

  localparam int tick_value        = 3;
  localparam int cycles_per_ms     = tick_value + 1;
  localparam int first_freq        = 554;  // intro index 0
  localparam int first_beats       = 6;
  localparam int before_rest_beats = 10;   // intro index 9
  localparam int rest_index        = 10;
  localparam int rest_beats        = 4;
  localparam int intro_beats       = 64;   // beat sums of the tables
  localparam int chorus_beats      = 132;
  localparam int loop_ms = (2 * intro_beats + 2 * chorus_beats) * tune_pkg::beat_ms * 4 / 3;
  localparam int loop_cycles     = loop_ms * cycles_per_ms;
  localparam int watchdog_cycles = 2 * loop_cycles;

  logic            clk;
  logic            rst;
  tune_pkg::tick_t ticks_per_milli;
  logic            sound;
  logic [7:0]      led;
  int              errors;
  int              checks;
  int              part_order [0:4] = '{1, 2, 3, 4, 1};

  tune_player uut (
    .clk             (clk),
    .rst             (rst),
    .ticks_per_milli (ticks_per_milli),
    .sound           (sound),
    .led             (led)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(watchdog_cycles * 4);
    $display("watchdog expired after %0d cycles, playback did not progress", watchdog_cycles);
    $display("TEST FAILED");
    $finish;
  end

  task automatic report_mismatch(string test, int expected, int actual);
    errors++;
    $display("mismatch %s: expected %0d, actual %0d", test, expected, actual);
  endtask

  // returns at the first falling edge after release
  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
  endtask

  task automatic wait_dot(logic level);
    while (led[7] !== level) @(negedge clk);
  endtask

  task automatic measure_dot(logic level, output int cycles);
    cycles = 0;
    while (led[7] === level) begin
      cycles++;
      @(negedge clk);
    end
  endtask

  task automatic check_idle_outputs(string test);
    checks += 3;
    if (sound !== 1'b0) report_mismatch(test, 0, int'(sound));
    if (led[7] !== 1'b0) report_mismatch(test, 0, int'(led[7]));
    if (led[6:0] !== tune_pkg::digit_segments[1])
      report_mismatch(test, int'(tune_pkg::digit_segments[1]), int'(led[6:0]));
  endtask

  // sounding length, then gap plus the idle cycle
  task automatic check_note_timing(string test);
    int high;
    int low;
    int exp_high;
    int exp_low;
    exp_high = first_beats * tune_pkg::beat_ms * cycles_per_ms;
    exp_low  = first_beats * tune_pkg::beat_ms / tune_pkg::gap_divisor * cycles_per_ms + 1;
    wait_dot(1'b1);
    measure_dot(1'b1, high);
    measure_dot(1'b0, low);
    checks += 2;
    if (high < exp_high - cycles_per_ms || high > exp_high + cycles_per_ms)
      report_mismatch(test, exp_high, high);
    if (low < exp_low - cycles_per_ms || low > exp_low + cycles_per_ms)
      report_mismatch(test, exp_low, low);
  endtask

  task automatic reset_state();
    apply_reset();
    check_idle_outputs("reset_state");
  endtask

  task automatic note_length();
    apply_reset();
    check_note_timing("note_length");
  endtask

  task automatic tone_pitch();
    int   rises;
    int   expected;
    logic prev;
    expected = first_freq * first_beats * tune_pkg::beat_ms / 1000;
    apply_reset();
    wait_dot(1'b1);
    rises = 0;
    prev  = sound;
    while (led[7] === 1'b1) begin
      if (sound && !prev) rises++;
      prev = sound;
      @(negedge clk);
    end
    checks++;
    if (rises < expected - 2 || rises > expected + 2)
      report_mismatch("tone_pitch", expected, rises);
  endtask

  task automatic rest_silence();
    int pulses;
    int dark;
    int loud;
    int expected;
    bit found;
    expected = (before_rest_beats * tune_pkg::beat_ms / tune_pkg::gap_divisor
                + rest_beats * tune_pkg::beat_ms
                + rest_beats * tune_pkg::beat_ms / tune_pkg::gap_divisor) * cycles_per_ms + 2;
    apply_reset();
    pulses = 0;
    found  = 1'b0;
    while (!found && pulses <= rest_index) begin
      wait_dot(1'b1);
      pulses++;
      wait_dot(1'b0);
      dark = 0;
      loud = 0;
      while (led[7] === 1'b0) begin
        if (dark > 0 && sound !== 1'b0) loud++;  // first cycle may still be high
        dark++;
        @(negedge clk);
      end
      if (dark > 500 * cycles_per_ms) found = 1'b1;  // longer than any plain gap
    end
    checks++;
    if (!found) begin
      errors++;
      $display("rest_silence: no silent stretch for the rest was seen");
    end else begin
      checks += 3;
      if (pulses != rest_index) report_mismatch("rest_silence", rest_index, pulses);
      if (dark < expected - 3 * cycles_per_ms || dark > expected + 3 * cycles_per_ms)
        report_mismatch("rest_silence", expected, dark);
      if (loud != 0) report_mismatch("rest_silence", 0, loud);
    end
  endtask

  task automatic part_sequence();
    int         step;
    logic [6:0] prev;
    apply_reset();
    step = 0;
    prev = led[6:0];
    checks++;
    if (prev !== tune_pkg::digit_segments[1])
      report_mismatch("part_sequence", int'(tune_pkg::digit_segments[1]), int'(prev));
    while (step < 4) begin
      @(negedge clk);
      if (led[6:0] !== prev) begin
        step++;
        checks++;
        if (led[6:0] !== tune_pkg::digit_segments[part_order[step]])
          report_mismatch("part_sequence", int'(tune_pkg::digit_segments[part_order[step]]),
                          int'(led[6:0]));
        prev = led[6:0];
      end
    end
  endtask

  task automatic reset_restart();
    apply_reset();
    while (led[6:0] !== tune_pkg::digit_segments[3]) @(negedge clk);
    wait_dot(1'b1);
    repeat (40) @(negedge clk);  // mid note in the chorus
    apply_reset();
    check_idle_outputs("reset_restart");
    check_note_timing("reset_restart");
  endtask

  initial begin
    errors = 0;
    checks = 0;
    rst <= 1'b1;
    ticks_per_milli <= 16'(tick_value);
    reset_state();
    note_length();
    tone_pitch();
    rest_silence();
    part_sequence();
    reset_restart();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
rtl/tune_pkg.sv
rtl/song_sequencer.sv
rtl/note_timer.sv
rtl/tone_generator.sv
rtl/tune_player.sv
bench/tune_player_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the tune player simulation with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module tune_player_tb \
  -o tune_player_sim > build.log 2>&1 && ./obj_dir/tune_player_sim > sim.log 2>&1
grep -q "^TEST PASSED$" sim.log && echo "simulation ok" || { echo "simulation failed, see build.log and sim.log"; exit 1; }
